/* build.f */
common/tdc_pkg.sv
common/tdc_hit_if.sv
capture/tdc_window.sv
capture/hit_recorder.sv
rtl/burst_out.sv
rtl/tdc_top.sv
verif/tdc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the TDC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f build.f --top-module tdc_tb -o tdc_sim

./obj_dir/tdc_sim | tee sim.log

if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"

/* verif/tdc_tb.sv */
`timescale 1ns/1ps

module tdc_tb;

    logic                         clk;
    logic                         rst_n;
    logic                         start_i;
    logic [tdc_pkg::TIME_W-1:0]   range_i;
    logic                         trigger_i;
    logic [tdc_pkg::PHASE_W-1:0]  phase_i;
    logic [tdc_pkg::SPAD_W-1:0]   spaden_i;
    logic                         ready_i;
    logic [tdc_pkg::TIME_W-1:0]   data_o;
    logic [tdc_pkg::INT_W-1:0]    int_o;
    logic [tdc_pkg::NUM_W-1:0]    num_o;
    logic                         last_o;
    logic                         valid_o;
    logic                         busy_o;

    // reference model of the running measurement
    int                           now_cnt;     // coarse count a trigger driven now gets
    int                           cur_range;
    int                           exp_n;
    logic [tdc_pkg::TIME_W-1:0]   exp_data [3];
    logic [tdc_pkg::INT_W-1:0]    exp_int [3];

    tdc_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .range_i   (range_i),
        .trigger_i (trigger_i),
        .phase_i   (phase_i),
        .spaden_i  (spaden_i),
        .ready_i   (ready_i),
        .data_o    (data_o),
        .int_o     (int_o),
        .num_o     (num_o),
        .last_o    (last_o),
        .valid_o   (valid_o),
        .busy_o    (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int ones_in(input logic [15:0] w);
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            n += int'(w[i]);
        end
        return n;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, want);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic start_meas(input int coarse);
        @(posedge clk);
        start_i <= 1'b1;
        range_i <= {10'(coarse), 5'($urandom)};   // fine bits do not matter
        @(posedge clk);
        start_i   <= 1'b0;
        now_cnt   = 0;
        cur_range = coarse;
        exp_n     = 0;
    endtask

    // start pulse that arrives while busy
    task automatic stray_start(input int coarse);
        start_i <= 1'b1;
        range_i <= {10'(coarse), 5'($urandom)};
        @(posedge clk);
        start_i <= 1'b0;
        now_cnt++;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        now_cnt += n;
    endtask

    task automatic hit(input bit all_spad);
        logic [15:0] ph;
        logic [15:0] sp;
        int          n_sp;
        ph   = 16'($urandom);
        sp   = all_spad ? 16'hffff : 16'($urandom);
        n_sp = ones_in(sp);
        trigger_i <= 1'b1;
        phase_i   <= ph;
        spaden_i  <= sp;
        // inside the window and a slot still free
        if (now_cnt <= cur_range && exp_n < 3) begin
            exp_data[exp_n] = {10'(now_cnt), 5'(ones_in(ph))};
            exp_int[exp_n]  = (n_sp > 15) ? 4'hf : 4'(n_sp);
            exp_n++;
        end
        @(posedge clk);
        trigger_i <= 1'b0;
        now_cnt++;
    endtask

    task automatic hold_low(input int n);
        repeat (n) begin
            @(negedge clk);
            check(32'(valid_o), 32'd0, "valid while ready is low");
        end
    endtask

    // --------------------------------------------------
    // burst checker
    // --------------------------------------------------
    task automatic check_burst();
        int waited;
        int beats;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 2000) begin
                $display("timeout: the result burst never started");
                $display("sim failed");
                $fatal(1, "timeout");
            end
        end while (valid_o !== 1'b1);
        beats = (exp_n == 0) ? 1 : exp_n;   // no-hit still sends one beat
        for (int i = 0; i < beats; i++) begin
            check(32'(valid_o), 32'd1, "valid during burst");
            check(32'(busy_o), 32'd1, "busy during burst");
            check(32'(data_o), (exp_n == 0) ? 32'h7fff : 32'(exp_data[i]), "beat data");
            check(32'(int_o), (exp_n == 0) ? 32'd0 : 32'(exp_int[i]), "beat intensity");
            check(32'(num_o), 32'(exp_n), "beat num");
            check(32'(last_o), 32'(i == beats - 1), "beat last");
            @(negedge clk);
        end
        check(32'(valid_o), 32'd0, "valid after last beat");
        check(32'(busy_o), 32'd0, "busy after last beat");
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic measure_without_hits();
        @(posedge clk);
        ready_i <= 1'b1;
        start_meas(2);
        check_burst();
    endtask

    task automatic record_two_hits();
        start_meas(12);
        idle(3);
        hit(1'b0);
        idle(4);
        hit(1'b0);
        check_burst();
    endtask

    task automatic overflow_hit_slots();
        start_meas(15);
        idle(2);
        hit(1'b0);
        hit(1'b1);   // saturated intensity
        hit(1'b0);
        hit(1'b0);
        hit(1'b0);
        check_burst();
    endtask

    task automatic stall_on_ready_low();
        @(posedge clk);
        ready_i <= 1'b0;
        start_meas(3);
        idle(2);
        hit(1'b0);
        hold_low(20);
        @(posedge clk);
        ready_i <= 1'b1;
        check_burst();
    endtask

    task automatic ignore_start_while_busy();
        start_meas(8);
        idle(1);
        hit(1'b0);
        stray_start(2);
        idle(3);
        hit(1'b0);   // past the stray range, inside the real one
        check_burst();
    endtask

    task automatic drop_late_trigger();
        @(posedge clk);
        ready_i <= 1'b0;
        start_meas(4);
        idle(1);
        hit(1'b0);
        idle(5);
        hit(1'b0);   // window already shut
        hold_low(10);
        @(posedge clk);
        ready_i <= 1'b1;
        check_burst();
    endtask

    initial begin
        void'($urandom(32'h87f28145));
        rst_n     = 1'b0;
        start_i   = 1'b0;
        range_i   = '0;
        trigger_i = 1'b0;
        phase_i   = '0;
        spaden_i  = '0;
        ready_i   = 1'b0;
        repeat (16) @(posedge clk);
        check(32'(valid_o), 32'd0, "valid in reset");
        check(32'(last_o), 32'd0, "last in reset");
        check(32'(busy_o), 32'd0, "busy in reset");
        rst_n <= 1'b1;
        measure_without_hits();
        record_two_hits();
        overflow_hit_slots();
        stall_on_ready_low();
        ignore_start_while_busy();
        drop_late_trigger();
        $display("sim passed");
        $finish;
    end

endmodule

/* rtl/tdc_top.sv */
`timescale 1ns/1ps

module tdc_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic [tdc_pkg::TIME_W-1:0]   range_i,
    input  logic                         trigger_i,   // from SPAD front end
    input  logic [tdc_pkg::PHASE_W-1:0]  phase_i,     // DLL phase taps
    input  logic [tdc_pkg::SPAD_W-1:0]   spaden_i,
    input  logic                         ready_i,
    output logic [tdc_pkg::TIME_W-1:0]   data_o,
    output logic [tdc_pkg::INT_W-1:0]    int_o,
    output logic [tdc_pkg::NUM_W-1:0]    num_o,
    output logic                         last_o,
    output logic                         valid_o,
    output logic                         busy_o
);

    logic                          win_open;
    logic [tdc_pkg::COARSE_W-1:0]  win_count;
    logic                          win_close;
    logic                          burst_end;

    tdc_hit_if hits ();

    // ------------------------------------------------
    // measurement window
    // ------------------------------------------------
    tdc_window i_window (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .range_i     (range_i),
        .burst_end_i (burst_end),
        .busy_o      (busy_o),
        .open_o      (win_open),
        .count_o     (win_count),
        .close_o     (win_close)
    );

    hit_recorder i_recorder (
        .clk       (clk),
        .rst_n     (rst_n),
        .open_i    (win_open),
        .count_i   (win_count),
        .close_i   (win_close),
        .trigger_i (trigger_i),
        .phase_i   (phase_i),
        .spaden_i  (spaden_i),
        .hits      (hits.recorder_mp)
    );

    // ------------------------------------------------
    // result burst
    // ------------------------------------------------
    burst_out i_burst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ready_i     (ready_i),
        .hits        (hits.sender_mp),
        .data_o      (data_o),
        .int_o       (int_o),
        .num_o       (num_o),
        .last_o      (last_o),
        .valid_o     (valid_o),
        .burst_end_o (burst_end)
    );

endmodule

/* rtl/burst_out.sv */
`timescale 1ns/1ps

module burst_out (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         ready_i,
    tdc_hit_if.sender_mp                 hits,
    output logic [tdc_pkg::TIME_W-1:0]   data_o,
    output logic [tdc_pkg::INT_W-1:0]    int_o,
    output logic [tdc_pkg::NUM_W-1:0]    num_o,
    output logic                         last_o,
    output logic                         valid_o,
    output logic                         burst_end_o
);

    logic [tdc_pkg::STATE_W-1:0] state;
    logic [tdc_pkg::NUM_W-1:0]   idx;       // next beat while in ST_BEAT
    logic [tdc_pkg::NUM_W-1:0]   cur;       // beat loaded this cycle
    logic [tdc_pkg::NUM_W-1:0]   beats;
    logic                        no_hit;
    logic                        launch;
    logic                        sending;
    logic                        is_last;

    // ------------------------------------------------
    // beat selection
    // ------------------------------------------------
    assign no_hit  = (hits.hit_num == '0);
    assign beats   = no_hit ? tdc_pkg::NUM_W'(1) : hits.hit_num;   // no-hit still sends one
    assign launch  = ready_i && (((state == tdc_pkg::ST_IDLE) && hits.done) ||
                                 (state == tdc_pkg::ST_WAIT));
    assign sending = launch || (state == tdc_pkg::ST_BEAT);   // ready ignored mid-burst
    assign cur     = launch ? '0 : idx;
    assign is_last = (cur == beats - tdc_pkg::NUM_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tdc_pkg::ST_IDLE;
            idx   <= '0;
        end else if (sending) begin
            idx   <= cur + tdc_pkg::NUM_W'(1);
            state <= is_last ? tdc_pkg::ST_IDLE : tdc_pkg::ST_BEAT;
        end else if ((state == tdc_pkg::ST_IDLE) && hits.done) begin
            state <= tdc_pkg::ST_WAIT;      // result ready, bus not
        end
    end

    // ------------------------------------------------
    // output registers
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
            last_o  <= 1'b0;
        end else begin
            valid_o <= sending;
            last_o  <= sending && is_last;
        end
    end

    always_ff @(posedge clk) begin
        if (sending) begin
            data_o <= no_hit ? tdc_pkg::NO_HIT_DATA : hits.tof[cur].raw;
            int_o  <= no_hit ? '0 : hits.intensity[cur];
            num_o  <= hits.hit_num;
        end
    end

    // frees the slots and ends busy
    assign hits.clear  = last_o;
    assign burst_end_o = last_o;

    // last closes the burst, nothing follows it directly
    a_last_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        last_o |-> valid_o ##1 !valid_o
    );

endmodule

/* capture/hit_recorder.sv */
`timescale 1ns/1ps

module hit_recorder (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          open_i,
    input  logic [tdc_pkg::COARSE_W-1:0]  count_i,
    input  logic                          close_i,
    input  logic                          trigger_i,
    input  logic [tdc_pkg::PHASE_W-1:0]   phase_i,
    input  logic [tdc_pkg::SPAD_W-1:0]    spaden_i,
    tdc_hit_if.recorder_mp                hits
);

    logic                        accept;
    tdc_pkg::tdc_time_u          hit_time;
    logic [tdc_pkg::INT_W-1:0]   int_sat;

    // room left and window open
    assign accept = trigger_i && open_i && (hits.hit_num < tdc_pkg::NUM_W'(tdc_pkg::MAX_HITS));

    // ------------------------------------------------
    // time word and intensity of the current trigger
    // ------------------------------------------------
    always_comb begin
        hit_time.field.coarse = count_i;
        hit_time.field.fine   = tdc_pkg::FINE_W'($countones(phase_i));   // thermometer to binary

        // more enabled SPADs than the field can hold
        if ($countones(spaden_i) > ((1 << tdc_pkg::INT_W) - 1)) begin
            int_sat = '1;
        end else begin
            int_sat = tdc_pkg::INT_W'($countones(spaden_i));
        end
    end

    // ------------------------------------------------
    // hit counter and done
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hits.hit_num <= '0;
        end else if (hits.clear) begin
            hits.hit_num <= '0;
        end else if (accept) begin
            hits.hit_num <= hits.hit_num + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hits.done <= 1'b0;
        end else begin
            hits.done <= close_i;   // one cycle behind close
        end
    end

    // slots, written in arrival order
    always_ff @(posedge clk) begin
        if (accept) begin
            hits.tof[hits.hit_num]       <= hit_time;
            hits.intensity[hits.hit_num] <= int_sat;
        end
    end

    // a full recorder only empties through the burst clear
    a_hit_limit: assert property (
        @(posedge clk) disable iff (!rst_n)
        (hits.hit_num == tdc_pkg::NUM_W'(tdc_pkg::MAX_HITS)) && !hits.clear
            |=> (hits.hit_num == tdc_pkg::NUM_W'(tdc_pkg::MAX_HITS))
    );

endmodule

/* capture/tdc_window.sv */
`timescale 1ns/1ps

module tdc_window (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  tdc_pkg::tdc_time_u            range_i,
    input  logic                          burst_end_i,   // last beat on the bus
    output logic                          busy_o,
    output logic                          open_o,
    output logic [tdc_pkg::COARSE_W-1:0]  count_o,
    output logic                          close_o
);

    logic               start_ok;
    tdc_pkg::tdc_time_u range_q;

    assign start_ok = start_i && !busy_o;   // starts while busy are dropped

    // close in the same cycle the count hits the range
    assign close_o = open_o && (count_o == range_q.field.coarse);

    // ------------------------------------------------
    // busy and range latch
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o <= 1'b0;
        end else if (start_ok) begin
            busy_o <= 1'b1;
        end else if (burst_end_i) begin
            busy_o <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            range_q <= tdc_pkg::RANGE_RESET;
        end else if (start_ok) begin
            range_q <= range_i;
        end
    end

    // ------------------------------------------------
    // window and coarse counter
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            open_o <= 1'b0;
        end else if (start_ok) begin
            open_o <= 1'b1;
        end else if (close_o) begin
            open_o <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_o <= '0;
        end else if (start_ok) begin
            count_o <= '0;              // first open cycle reads zero
        end else if (open_o && !close_o) begin
            count_o <= count_o + 1'b1;
        end
    end

    // window must be shut long before the burst releases busy
    a_open_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        open_o |-> busy_o
    );

endmodule

/* common/tdc_hit_if.sv */
`timescale 1ns/1ps

interface tdc_hit_if;

    logic [tdc_pkg::NUM_W-1:0]                         hit_num;    // hits stored so far
    tdc_pkg::tdc_time_u [tdc_pkg::MAX_HITS-1:0]        tof;
    logic [tdc_pkg::MAX_HITS-1:0][tdc_pkg::INT_W-1:0]  intensity;
    logic                                              done;       // result complete
    logic                                              clear;      // last beat sent

    // capture side owns the slots
    modport recorder_mp (
        output hit_num,
        output tof,
        output intensity,
        output done,
        input  clear
    );

    // output side reads them and frees them again
    modport sender_mp (
        input  hit_num,
        input  tof,
        input  intensity,
        input  done,
        output clear
    );

endinterface

/* common/tdc_pkg.sv */
package tdc_pkg;

    // ------------------------------------------------
    // widths
    // ------------------------------------------------
    localparam int COARSE_W = 10;   // coarse counter
    localparam int FINE_W   = 5;    // ones in the phase word, 0..16
    localparam int TIME_W   = COARSE_W + FINE_W;
    localparam int PHASE_W  = 16;   // DLL taps
    localparam int SPAD_W   = 16;   // 4x4 array
    localparam int INT_W    = 4;
    localparam int NUM_W    = 2;

    // ------------------------------------------------
    // limits and fixed words
    // ------------------------------------------------
    localparam int MAX_HITS = 3;

    localparam logic [TIME_W-1:0] NO_HIT_DATA = '1;
    localparam logic [TIME_W-1:0] RANGE_RESET = '1;   // widest window until first start

    // output FSM encoding
    localparam int             STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
    localparam logic [STATE_W-1:0] ST_WAIT = 2'd1;   // result held, ready low
    localparam logic [STATE_W-1:0] ST_BEAT = 2'd2;

    // time word, seen as a raw value on the bus side
    // and as coarse/fine fields inside the core
    typedef union packed {
        logic [TIME_W-1:0] raw;
        struct packed {
            logic [COARSE_W-1:0] coarse;   // upper bits
            logic [FINE_W-1:0]   fine;
        } field;
    } tdc_time_u;

endpackage
